// File: source/i2cm_pkg.sv
/*
  Shared widths, local-bus register map and reset constants
  Packed structs for the local bus, engine configuration and I2C pin drive
*/
`default_nettype none

package i2cm_pkg;

  // Local bus geometry
  localparam int unsigned LB_ADDR_W = 8;
  localparam int unsigned LB_DATA_W = 16;

  // I2C transfer geometry, the data word goes out as two bytes
  localparam int unsigned I2C_ADDR_W = 8;
  localparam int unsigned I2C_DATA_W = 16;
  localparam int unsigned PAYLOAD_W  = I2C_ADDR_W + I2C_DATA_W;

  // Divider range is 3 to 255 clocks per bit minus one
  localparam int unsigned CLK_DIV_W = 8;
  localparam int unsigned BIT_CNT_W = 5;

  // Register map
  localparam logic [LB_ADDR_W-1:0] REG_STATUS_ADDR  = 8'h00;
  localparam logic [LB_ADDR_W-1:0] REG_ADDR_ADDR    = 8'h01;
  localparam logic [LB_ADDR_W-1:0] REG_DATA_ADDR    = 8'h02;
  localparam logic [LB_ADDR_W-1:0] REG_CLK_DIV_ADDR = 8'h03;

  // Slowest bit rate out of reset
  localparam logic [CLK_DIV_W-1:0] CLK_DIV_RST = 8'hFF;

  // Read-back for addresses outside the map
  localparam logic [LB_DATA_W-1:0] RD_UNMAPPED = 16'hDEAD;

  // Host request, one access per cycle
  typedef struct packed {
    logic                 wr_en;
    logic                 rd_en;
    logic [LB_ADDR_W-1:0] addr;
    logic [LB_DATA_W-1:0] wr_data;
  } lb_req_t;

  // Response, both valids lag their enables by one cycle
  typedef struct packed {
    logic                 wr_valid;
    logic                 rd_valid;
    logic [LB_DATA_W-1:0] rd_data;
  } lb_rsp_t;

  // Configuration held by the register file
  typedef struct packed {
    logic [I2C_ADDR_W-1:0] slave_addr;
    logic [I2C_DATA_W-1:0] data;
    logic [CLK_DIV_W-1:0]  clk_div;
  } i2c_cfg_t;

  // Pin drive, SDA floats while sda_release is high
  typedef struct packed {
    logic scl;
    logic sda;
    logic sda_release;
  } i2c_pins_t;

endpackage

`default_nettype wire

// File: source/i2cm_regs.sv
/*
  Local-bus register file for the I2C write master
  Holds slave address, data and divider, decodes the start write
  and returns a registered read mux with status from the engine
*/
`default_nettype none

module i2cm_regs
(
  input  logic                cr_intf,
  input  logic                rst_n_i,
  input  i2cm_pkg::lb_req_t   lb_req_i,
  output i2cm_pkg::lb_rsp_t   lb_rsp_o,
  input  logic                busy_i,
  input  logic                nack_i,
  output i2cm_pkg::i2c_cfg_t  cfg_o,
  output logic                start_o
);

  // Config is frozen from the start pulse until the engine goes idle
  logic                             locked;
  logic                             wr_status;
  logic [i2cm_pkg::LB_DATA_W-1:0]   rd_mux;

  // Start pulse already issued counts as busy
  assign locked = busy_i | start_o;

  // Write strobe aimed at the status register
  assign wr_status = lb_req_i.wr_en & (lb_req_i.addr == i2cm_pkg::REG_STATUS_ADDR);

  // Configuration registers
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cfg_o.slave_addr <= '0;
      cfg_o.data       <= '0;
      cfg_o.clk_div    <= i2cm_pkg::CLK_DIV_RST;
    end
    else if (lb_req_i.wr_en && !locked)
    begin
      case (lb_req_i.addr)
        i2cm_pkg::REG_ADDR_ADDR:
        begin
          cfg_o.slave_addr <= lb_req_i.wr_data[i2cm_pkg::I2C_ADDR_W-1:0];
        end
        i2cm_pkg::REG_DATA_ADDR:
        begin
          cfg_o.data <= lb_req_i.wr_data[i2cm_pkg::I2C_DATA_W-1:0];
        end
        i2cm_pkg::REG_CLK_DIV_ADDR:
        begin
          cfg_o.clk_div <= lb_req_i.wr_data[i2cm_pkg::CLK_DIV_W-1:0];
        end
        default:
        begin
          // Status write carries no stored data
          cfg_o <= cfg_o;
        end
      endcase
    end
  end

  // One-cycle start pulse
  // A status write while a transfer runs is dropped
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      start_o <= 1'b0;
    end
    else
    begin
      start_o <= wr_status & ~locked;
    end
  end

  // Read mux, narrow registers are zero extended
  always_comb
  begin
    case (lb_req_i.addr)
      i2cm_pkg::REG_STATUS_ADDR:
      begin
        // Bit 1 sticky NACK, bit 0 busy
        rd_mux = {{(i2cm_pkg::LB_DATA_W-2){1'b0}}, nack_i, busy_i};
      end
      i2cm_pkg::REG_ADDR_ADDR:    rd_mux = i2cm_pkg::LB_DATA_W'(cfg_o.slave_addr);
      i2cm_pkg::REG_DATA_ADDR:    rd_mux = i2cm_pkg::LB_DATA_W'(cfg_o.data);
      i2cm_pkg::REG_CLK_DIV_ADDR: rd_mux = i2cm_pkg::LB_DATA_W'(cfg_o.clk_div);
      default:                    rd_mux = i2cm_pkg::RD_UNMAPPED;
    endcase
  end

  // Response path
  // Writes acknowledge even when ignored while busy
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lb_rsp_o <= '0;
    end
    else
    begin
      lb_rsp_o.wr_valid <= lb_req_i.wr_en;
      lb_rsp_o.rd_valid <= lb_req_i.rd_en;
      if (lb_req_i.rd_en)
      begin
        lb_rsp_o.rd_data <= rd_mux;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/i2cm_bit_timer.sv
/*
  Bit-period counter for the I2C master
  Wraps at the divider and decodes end, half and quarter ticks
*/
`default_nettype none

module i2cm_bit_timer
(
  input  logic                            cr_intf,
  input  logic                            rst_n_i,
  input  logic                            run_i,
  input  logic [i2cm_pkg::CLK_DIV_W-1:0]  clk_div_i,
  output logic                            bit_end_o,
  output logic                            half_tick_o,
  output logic                            quarter_tick_o
);

  // Position inside the current bit, 0 to clk_div
  logic [i2cm_pkg::CLK_DIV_W-1:0] cnt_q;

  // Tick positions derived from the divider
  logic [i2cm_pkg::CLK_DIV_W-1:0] half_pos;
  logic [i2cm_pkg::CLK_DIV_W-1:0] quarter_pos;

  assign half_pos    = clk_div_i >> 1;
  assign quarter_pos = clk_div_i >> 2;

  // Last clock of the bit
  // A bit therefore lasts clk_div plus one clocks
  assign bit_end_o = run_i & (cnt_q == clk_div_i);

  // Sampling point, SCL is high here
  assign half_tick_o = run_i & (cnt_q == half_pos);

  // SCL rising point
  // Always before the half tick for legal dividers
  assign quarter_tick_o = run_i & (cnt_q == quarter_pos);

  // Counter held at 0 while idle so each transfer starts on a bit boundary
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
    end
    else if (!run_i || bit_end_o)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/i2cm_engine.sv
/*
  I2C write transaction FSM
  Sends address and two data bytes MSB first, checks each ACK slot,
  generates registered SCL and SDA from the bit timer ticks
*/
`default_nettype none

module i2cm_engine
(
  input  logic                cr_intf,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  i2cm_pkg::i2c_cfg_t  cfg_i,
  input  logic                bit_end_i,
  input  logic                half_tick_i,
  input  logic                quarter_tick_i,
  input  logic                sda_i,
  output logic                run_o,
  output logic                busy_o,
  output logic                nack_o,
  output i2cm_pkg::i2c_pins_t pins_o
);

  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_START,
    ST_ADDR,
    ST_DATA,
    ST_ACK,
    ST_STOP
  } state_e;

  state_e                           state_q;
  state_e                           state_d;
  logic [i2cm_pkg::BIT_CNT_W-1:0]   bit_idx_q;
  logic [i2cm_pkg::PAYLOAD_W-1:0]   shift_q;
  logic [i2cm_pkg::CLK_DIV_W-1:0]   quarter_len;
  logic [i2cm_pkg::CLK_DIV_W-1:0]   fall_cnt_q;
  logic                             fall_arm_q;
  logic                             nack_q;
  logic                             scl_q;
  logic                             sda_q;
  logic                             sda_rel_q;
  logic                             idle;
  logic                             take_start;
  logic                             byte_last;
  logic                             all_sent;
  logic                             go_stop;

  assign idle       = (state_q == ST_IDLE);
  assign take_start = idle & start_i;

  // Eighth bit of the current byte
  assign byte_last = (bit_idx_q[2:0] == 3'd7);

  // All three bytes have gone out
  assign all_sent = (bit_idx_q == i2cm_pkg::BIT_CNT_W'(i2cm_pkg::PAYLOAD_W));

  // Leave through STOP after a NACK or after the last byte
  assign go_stop = nack_q | all_sent;

  // Quarter of a bit, the SCL low time after the half tick
  assign quarter_len = cfg_i.clk_div >> 2;

  // Next state, every move except the start lands on a bit boundary
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (start_i)                 state_d = ST_START;
      ST_START: if (bit_end_i)               state_d = ST_ADDR;
      ST_ADDR:  if (bit_end_i && byte_last)  state_d = ST_ACK;
      ST_DATA:  if (bit_end_i && byte_last)  state_d = ST_ACK;
      ST_ACK:
      begin
        if (bit_end_i)
        begin
          state_d = go_stop ? ST_STOP : ST_DATA;
        end
      end
      ST_STOP:  if (bit_end_i)               state_d = ST_IDLE;
      default:                               state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Bit index over the 24 payload bits, held through ACK slots
  // NACK flag is sticky and cleared only by the next start
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bit_idx_q <= '0;
      nack_q    <= 1'b0;
    end
    else
    begin
      if (idle)
      begin
        bit_idx_q <= '0;
      end
      else if (bit_end_i && (state_q == ST_ADDR || state_q == ST_DATA))
      begin
        bit_idx_q <= bit_idx_q + 1'b1;
      end

      if (take_start)
      begin
        nack_q <= 1'b0;
      end
      else if (state_q == ST_ACK && half_tick_i && scl_q && sda_i)
      begin
        // Slave left SDA high in the ACK slot
        nack_q <= 1'b1;
      end
    end
  end

  // Payload shifter, MSB is the bit on the wire
  always_ff @(posedge cr_intf)
  begin
    if (take_start)
    begin
      shift_q <= {cfg_i.slave_addr, cfg_i.data};
    end
    else if (bit_end_i && (state_q == ST_ADDR || state_q == ST_DATA))
    begin
      shift_q <= shift_q << 1;
    end
  end

  // SCL
  // Rise on the quarter tick, fall a quarter after the half tick
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      scl_q      <= 1'b1;
      fall_cnt_q <= '0;
      fall_arm_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_START:
        begin
          // SDA is already low, this completes the START condition
          if (half_tick_i)
          begin
            scl_q <= 1'b0;
          end
        end
        ST_ADDR, ST_DATA, ST_ACK:
        begin
          if (quarter_tick_i)
          begin
            scl_q <= 1'b1;
          end
          if (half_tick_i)
          begin
            if (quarter_len == '0)
            begin
              scl_q <= 1'b0;
            end
            else
            begin
              fall_cnt_q <= quarter_len - 1'b1;
              fall_arm_q <= 1'b1;
            end
          end
          else if (fall_arm_q)
          begin
            if (fall_cnt_q == '0)
            begin
              scl_q      <= 1'b0;
              fall_arm_q <= 1'b0;
            end
            else
            begin
              fall_cnt_q <= fall_cnt_q - 1'b1;
            end
          end
        end
        ST_STOP:
        begin
          // SCL stays high once it rises
          if (quarter_tick_i)
          begin
            scl_q <= 1'b1;
          end
        end
        default:
        begin
          scl_q      <= 1'b1;
          fall_arm_q <= 1'b0;
        end
      endcase
    end
  end

  // SDA
  // Changes only on bit ends while SCL is low, except START and STOP
  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sda_q     <= 1'b1;
      sda_rel_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          sda_rel_q <= 1'b0;
          // START condition, SDA falls with SCL still high
          if (start_i)
          begin
            sda_q <= 1'b0;
          end
          else
          begin
            sda_q <= 1'b1;
          end
        end
        ST_START:
        begin
          if (bit_end_i)
          begin
            sda_q <= shift_q[i2cm_pkg::PAYLOAD_W-1];
          end
        end
        ST_ADDR, ST_DATA:
        begin
          if (bit_end_i)
          begin
            if (byte_last)
            begin
              // Hand SDA to the slave for the ACK slot
              sda_rel_q <= 1'b1;
            end
            else
            begin
              sda_q <= shift_q[i2cm_pkg::PAYLOAD_W-2];
            end
          end
        end
        ST_ACK:
        begin
          if (bit_end_i)
          begin
            sda_rel_q <= 1'b0;
            // Low ahead of STOP, or first bit of the next byte
            sda_q     <= go_stop ? 1'b0 : shift_q[i2cm_pkg::PAYLOAD_W-1];
          end
        end
        ST_STOP:
        begin
          // STOP condition, SCL is high by the half tick
          if (half_tick_i)
          begin
            sda_q <= 1'b1;
          end
        end
        default:
        begin
          sda_q     <= 1'b1;
          sda_rel_q <= 1'b0;
        end
      endcase
    end
  end

  assign pins_o = '{scl: scl_q, sda: sda_q, sda_release: sda_rel_q};

  // Timer runs for the whole transaction
  assign run_o  = ~idle;
  assign busy_o = ~idle;
  assign nack_o = nack_q;

endmodule

`default_nettype wire

// File: source/i2cm_top.sv
/*
  I2C write master top level
  Register file, bit timer and transaction engine
*/
`default_nettype none

module i2cm_top
(
  input  logic                 cr_intf,
  input  logic                 rst_n_i,
  input  i2cm_pkg::lb_req_t    lb_req_i,
  output i2cm_pkg::lb_rsp_t    lb_rsp_o,
  input  logic                 sda_i,
  output i2cm_pkg::i2c_pins_t  i2c_pins_o
);

  i2cm_pkg::i2c_cfg_t cfg;
  logic               start;
  logic               busy;
  logic               nack;
  logic               run;
  logic               bit_end;
  logic               half_tick;
  logic               quarter_tick;

  // Host side registers and status
  i2cm_regs u_regs
  (
    .cr_intf  (cr_intf),
    .rst_n_i  (rst_n_i),
    .lb_req_i (lb_req_i),
    .lb_rsp_o (lb_rsp_o),
    .busy_i   (busy),
    .nack_i   (nack),
    .cfg_o    (cfg),
    .start_o  (start)
  );

  // Bit period and SCL phase ticks
  i2cm_bit_timer u_bit_timer
  (
    .cr_intf        (cr_intf),
    .rst_n_i        (rst_n_i),
    .run_i          (run),
    .clk_div_i      (cfg.clk_div),
    .bit_end_o      (bit_end),
    .half_tick_o    (half_tick),
    .quarter_tick_o (quarter_tick)
  );

  // Transaction sequencing and pin drive
  i2cm_engine u_engine
  (
    .cr_intf        (cr_intf),
    .rst_n_i        (rst_n_i),
    .start_i        (start),
    .cfg_i          (cfg),
    .bit_end_i      (bit_end),
    .half_tick_i    (half_tick),
    .quarter_tick_i (quarter_tick),
    .sda_i          (sda_i),
    .run_o          (run),
    .busy_o         (busy),
    .nack_o         (nack),
    .pins_o         (i2c_pins_o)
  );

endmodule

`default_nettype wire

// File: sim/i2cm_slave_model.sv
/*
  Behavioral I2C codec slave for the write master testbench
  Detects START and STOP, captures bytes, drives ACK or NACK
  and reports the spacing of SCL rising edges in clock cycles
*/
`default_nettype none

module i2cm_slave_model
(
  input  logic        cr_intf,
  input  logic        rst_n_i,
  input  logic        scl_i,
  input  logic        sda_i,
  input  logic        nack_addr_i,
  output logic        sda_pull_o,
  output logic        start_o,
  output logic        stop_o,
  output logic        misplaced_o,
  output logic        byte_valid_o,
  output logic [7:0]  byte_o,
  output logic        period_valid_o,
  output logic [15:0] period_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Bus levels seen on the previous clock
  logic        scl_q;
  logic        sda_q;
  // Frame tracking between START and STOP
  logic        in_frame;
  logic        rise_seen;
  logic        have_rise;
  logic        bit_val;
  logic [3:0]  bit_cnt;
  logic [3:0]  byte_idx;
  logic [7:0]  shift;
  // Free-running cycle count for SCL spacing
  logic [15:0] cycle_cnt;
  logic [15:0] last_rise;
  logic        scl_rise;
  logic        scl_fall;
  logic        sda_fall_hi;
  logic        sda_rise_hi;
  logic        both_move;

  assign scl_rise    = scl_i & ~scl_q;
  assign scl_fall    = ~scl_i & scl_q;
  // START and STOP are the only SDA moves allowed with SCL high
  assign sda_fall_hi = scl_i & scl_q & sda_q & ~sda_i;
  assign sda_rise_hi = scl_i & scl_q & ~sda_q & sda_i;
  // SDA and SCL switching on the same clock is never legal
  assign both_move   = (scl_i ^ scl_q) & (sda_i ^ sda_q);

  always_ff @(posedge cr_intf or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      scl_q          <= 1'b1;
      sda_q          <= 1'b1;
      in_frame       <= 1'b0;
      rise_seen      <= 1'b0;
      have_rise      <= 1'b0;
      bit_val        <= 1'b0;
      bit_cnt        <= '0;
      byte_idx       <= '0;
      shift          <= '0;
      cycle_cnt      <= '0;
      last_rise      <= '0;
      sda_pull_o     <= 1'b0;
      start_o        <= 1'b0;
      stop_o         <= 1'b0;
      misplaced_o    <= 1'b0;
      byte_valid_o   <= 1'b0;
      byte_o         <= '0;
      period_valid_o <= 1'b0;
      period_o       <= '0;
    end
    else
    begin
      scl_q          <= scl_i;
      sda_q          <= sda_i;
      cycle_cnt      <= cycle_cnt + 1'b1;
      start_o        <= 1'b0;
      stop_o         <= 1'b0;
      misplaced_o    <= both_move;
      byte_valid_o   <= 1'b0;
      period_valid_o <= 1'b0;
      if (sda_fall_hi)
      begin
        // Repeated START is not part of this bus
        if (in_frame)
        begin
          misplaced_o <= 1'b1;
        end
        start_o    <= 1'b1;
        in_frame   <= 1'b1;
        rise_seen  <= 1'b0;
        have_rise  <= 1'b0;
        bit_cnt    <= '0;
        byte_idx   <= '0;
        sda_pull_o <= 1'b0;
      end
      else if (sda_rise_hi)
      begin
        // STOP only on a byte boundary after the ACK clock
        if (!in_frame || bit_cnt != 4'd0)
        begin
          misplaced_o <= 1'b1;
        end
        stop_o   <= 1'b1;
        in_frame <= 1'b0;
      end
      else if (in_frame && scl_rise)
      begin
        // Latch the bit, commit it when SCL falls
        bit_val   <= sda_i;
        rise_seen <= 1'b1;
        have_rise <= 1'b1;
        last_rise <= cycle_cnt;
        if (have_rise)
        begin
          period_valid_o <= 1'b1;
          period_o       <= cycle_cnt - last_rise;
        end
      end
      else if (in_frame && scl_fall && rise_seen)
      begin
        rise_seen <= 1'b0;
        if (bit_cnt == 4'd8)
        begin
          // End of the ACK clock, let go of SDA
          bit_cnt    <= '0;
          byte_idx   <= byte_idx + 1'b1;
          sda_pull_o <= 1'b0;
        end
        else
        begin
          shift   <= {shift[6:0], bit_val};
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd7)
          begin
            byte_valid_o <= 1'b1;
            byte_o       <= {shift[6:0], bit_val};
            // ACK by pulling low, NACK leaves the line released
            sda_pull_o   <= ~(nack_addr_i && byte_idx == 4'd0);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_i2cm.sv
/*
  Testbench for the I2C write master
  Clock, reset, local-bus tasks, reference function, checker, watchdog
  Directed register and transfer tests, then random transfers
*/
`default_nettype none

module tb_i2cm;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD   = 40;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned N_RANDOM     = 6;
  // Four directed transfers plus the random ones
  localparam int unsigned N_TRANS      = N_RANDOM + 4;
  localparam longint unsigned WATCHDOG_NS = 2 * N_TRANS * 29 * 256 * CLK_PERIOD;
  localparam int unsigned POLL_LIMIT   = 29 * 256;
  localparam logic [31:0] SEED         = 32'h9525_fa41;

  // Expected outcome of one transfer
  typedef struct packed {
    logic [23:0] bytes;
    logic [1:0]  n_bytes;
    logic        nack;
    logic [15:0] period;
  } expect_t;

  logic                  cr_intf;
  logic                  rst_n;
  i2cm_pkg::lb_req_t     req;
  i2cm_pkg::lb_rsp_t     rsp;
  i2cm_pkg::i2c_pins_t   pins;
  logic                  sda_bus;
  logic                  sda_pull;
  logic                  nack_addr;
  logic                  start_ev;
  logic                  stop_ev;
  logic                  misplaced;
  logic                  byte_valid;
  logic [7:0]            byte_val;
  logic                  period_valid;
  logic [15:0]           period;
  logic [7:0]            exp_q[$];
  logic [15:0]           exp_period;
  int unsigned           n_starts;
  int unsigned           n_stops;

  // Wired-AND bus with pull-up so a released master reads high
  assign sda_bus = (pins.sda_release | pins.sda) & ~sda_pull;

  i2cm_top DUT
  (
    .cr_intf    (cr_intf),
    .rst_n_i    (rst_n),
    .lb_req_i   (req),
    .lb_rsp_o   (rsp),
    .sda_i      (sda_bus),
    .i2c_pins_o (pins)
  );

  i2cm_slave_model u_slave
  (
    .cr_intf        (cr_intf),
    .rst_n_i        (rst_n),
    .scl_i          (pins.scl),
    .sda_i          (sda_bus),
    .nack_addr_i    (nack_addr),
    .sda_pull_o     (sda_pull),
    .start_o        (start_ev),
    .stop_o         (stop_ev),
    .misplaced_o    (misplaced),
    .byte_valid_o   (byte_valid),
    .byte_o         (byte_val),
    .period_valid_o (period_valid),
    .period_o       (period)
  );

  initial
  begin
    cr_intf = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) cr_intf = ~cr_intf;
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Run aborted");
  endtask

  // Single write whose valid must pulse for exactly the next cycle
  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    @(negedge cr_intf);
    req.wr_en   = 1'b1;
    req.addr    = addr;
    req.wr_data = data;
    @(negedge cr_intf);
    req.wr_en = 1'b0;
    check("wr_valid one cycle after wr_en", rsp.wr_valid, 1);
    @(negedge cr_intf);
    check("wr_valid pulse width", rsp.wr_valid, 0);
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [15:0] data);
    @(negedge cr_intf);
    req.rd_en = 1'b1;
    req.addr  = addr;
    @(negedge cr_intf);
    req.rd_en = 1'b0;
    check("rd_valid one cycle after rd_en", rsp.rd_valid, 1);
    data = rsp.rd_data;
    @(negedge cr_intf);
    check("rd_valid pulse width", rsp.rd_valid, 0);
  endtask

  // Address byte then data MSB first
  // A NACKed address ends the frame
  function automatic expect_t predict_transfer(i2cm_pkg::i2c_cfg_t cfg, logic nack_first);
    expect_t e;
    e.bytes   = {cfg.slave_addr, cfg.data};
    e.n_bytes = nack_first ? 2'd1 : 2'd3;
    e.nack    = nack_first;
    e.period  = 16'(cfg.clk_div) + 16'd1;
    return e;
  endfunction

  // Program, start, optionally poke while busy, then poll for idle
  task automatic run_transfer(input i2cm_pkg::i2c_cfg_t cfg, input logic nack_first,
                              input logic poke_busy);
    expect_t     e;
    logic [15:0] rd;
    int unsigned starts_before;
    int unsigned stops_before;
    int unsigned polls;
    e = predict_transfer(cfg, nack_first);
    @(negedge cr_intf);
    nack_addr = nack_first;
    bus_write(i2cm_pkg::REG_ADDR_ADDR, 16'(cfg.slave_addr));
    bus_write(i2cm_pkg::REG_DATA_ADDR, cfg.data);
    bus_write(i2cm_pkg::REG_CLK_DIV_ADDR, 16'(cfg.clk_div));
    for (int i = 0; i < int'(e.n_bytes); i++)
    begin
      exp_q.push_back(e.bytes[23 - 8 * i -: 8]);
    end
    exp_period    = e.period;
    starts_before = n_starts;
    stops_before  = n_stops;
    bus_write(i2cm_pkg::REG_STATUS_ADDR, 16'h0001);
    // Busy set and sticky NACK cleared by the start
    bus_read(i2cm_pkg::REG_STATUS_ADDR, rd);
    check("status right after start", rd, 16'h0001);
    if (poke_busy)
    begin
      bus_write(i2cm_pkg::REG_ADDR_ADDR, 16'(~cfg.slave_addr));
      bus_write(i2cm_pkg::REG_DATA_ADDR, ~cfg.data);
      bus_write(i2cm_pkg::REG_CLK_DIV_ADDR, 16'(cfg.clk_div ^ 8'h0F));
      bus_write(i2cm_pkg::REG_STATUS_ADDR, 16'h0001);
      bus_read(i2cm_pkg::REG_ADDR_ADDR, rd);
      check("address held while busy", rd, 16'(cfg.slave_addr));
      bus_read(i2cm_pkg::REG_DATA_ADDR, rd);
      check("data held while busy", rd, cfg.data);
      bus_read(i2cm_pkg::REG_CLK_DIV_ADDR, rd);
      check("divider held while busy", rd, 16'(cfg.clk_div));
      bus_read(i2cm_pkg::REG_STATUS_ADDR, rd);
    end
    polls = 0;
    while (rd[0])
    begin
      bus_read(i2cm_pkg::REG_STATUS_ADDR, rd);
      polls++;
      if (polls > POLL_LIMIT)
      begin
        fail_run("Transfer did not finish, busy stayed high");
      end
    end
    check("status after transfer", rd, {14'b0, e.nack, 1'b0});
    check("bytes still expected at STOP", exp_q.size(), 0);
    check("START conditions in transfer", n_starts - starts_before, 1);
    check("STOP conditions in transfer", n_stops - stops_before, 1);
  endtask

  // Compares every event of the slave model against the prediction
  always @(negedge cr_intf)
  begin
    if (start_ev)
    begin
      n_starts++;
    end
    if (stop_ev)
    begin
      n_stops++;
    end
    if (misplaced)
    begin
      fail_run("SDA changed while SCL was high outside a START or STOP");
    end
    else if (byte_valid && exp_q.size() == 0)
    begin
      fail_run("Slave model captured a byte that was not expected");
    end
    else if (byte_valid)
    begin
      check("captured byte", byte_val, exp_q.pop_front());
    end
    if (period_valid)
    begin
      check("SCL rising edge spacing", period, exp_period);
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Regression failed");
    $fatal(1, "Timeout");
  end

  initial
  begin
    logic [15:0]        rd;
    i2cm_pkg::i2c_cfg_t cfg;
    logic               nack_first;
    void'($urandom(SEED));
    req        = '0;
    nack_addr  = 1'b0;
    rst_n      = 1'b0;
    n_starts   = 0;
    n_stops    = 0;
    exp_period = '0;
    repeat (RESET_CYCLES) @(posedge cr_intf);
    @(negedge cr_intf);
    rst_n = 1'b1;

    // Reset state of pins and registers
    check("SCL idle level", pins.scl, 1);
    check("SDA idle level", sda_bus, 1);
    check("SDA release after reset", pins.sda_release, 0);
    bus_read(i2cm_pkg::REG_STATUS_ADDR, rd);
    check("status after reset", rd, 16'h0000);
    bus_read(i2cm_pkg::REG_ADDR_ADDR, rd);
    check("address after reset", rd, 16'h0000);
    bus_read(i2cm_pkg::REG_DATA_ADDR, rd);
    check("data after reset", rd, 16'h0000);
    bus_read(i2cm_pkg::REG_CLK_DIV_ADDR, rd);
    check("divider after reset", rd, 16'h00FF);

    // Write then read back each configuration register
    bus_write(i2cm_pkg::REG_ADDR_ADDR, 16'h0034);
    bus_read(i2cm_pkg::REG_ADDR_ADDR, rd);
    check("address readback", rd, 16'h0034);
    bus_write(i2cm_pkg::REG_DATA_ADDR, 16'hBEEF);
    bus_read(i2cm_pkg::REG_DATA_ADDR, rd);
    check("data readback", rd, 16'hBEEF);
    bus_write(i2cm_pkg::REG_CLK_DIV_ADDR, 16'h0007);
    bus_read(i2cm_pkg::REG_CLK_DIV_ADDR, rd);
    check("divider readback", rd, 16'h0007);

    // Addresses outside the map
    bus_read(8'h04, rd);
    check("unmapped read 0x04", rd, 16'hDEAD);
    bus_read(8'hFF, rd);
    check("unmapped read 0xFF", rd, 16'hDEAD);

    // Acknowledged transfer
    cfg = '{slave_addr: 8'h34, data: 16'h1A2B, clk_div: 8'd5};
    run_transfer(cfg, 1'b0, 1'b0);

    // NACKed address then a start that clears the flag
    cfg = '{slave_addr: 8'h94, data: 16'hC3E1, clk_div: 8'd4};
    run_transfer(cfg, 1'b1, 1'b0);
    run_transfer(cfg, 1'b0, 1'b0);

    // Config writes and a second start while busy are ignored
    cfg = '{slave_addr: 8'h1A, data: 16'h5AA5, clk_div: 8'd10};
    run_transfer(cfg, 1'b0, 1'b1);

    // Random transfers with dividers 3 to 20
    for (int n = 0; n < int'(N_RANDOM); n++)
    begin
      cfg.slave_addr = 8'($urandom());
      cfg.data       = 16'($urandom());
      cfg.clk_div    = 8'(3 + ($urandom() % 18));
      nack_first     = (($urandom() % 4) == 0);
      run_transfer(cfg, nack_first, 1'b0);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
source/i2cm_pkg.sv
source/i2cm_regs.sv
source/i2cm_bit_timer.sv
source/i2cm_engine.sv
source/i2cm_top.sv
sim/i2cm_slave_model.sv
sim/tb_i2cm.sv

// File: Bender.yml
package:
  name: i2cm

sources:
  - source/i2cm_pkg.sv
  - source/i2cm_regs.sv
  - source/i2cm_bit_timer.sv
  - source/i2cm_engine.sv
  - source/i2cm_top.sv
  - target: simulation
    files:
      - sim/i2cm_slave_model.sv
      - sim/tb_i2cm.sv
